// File: files.f
obj_pkg.sv
obj_table.sv
obj_draw.sv
obj_line_buf.sv
obj_line_unit.sv
obj_line_unit_sva.sv
tb_clk_gen.sv
tb_obj_line_unit.sv

// File: obj_draw.sv
`timescale 1ns/1ps
`default_nettype none

module obj_draw #(
    parameter int obj_slots = 121
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    output obj_pkg::tbl_addr_t rd_addr,
    input  obj_pkg::tbl_word_t rd_data,
    output logic               rom_cs,
    output logic               rom_half,
    output obj_pkg::rom_addr_t rom_addr,
    input  obj_pkg::rom_word_t rom_data,
    input  logic               rom_ok,
    output logic               buf_wr,
    output obj_pkg::buf_addr_t buf_addr,
    output obj_pkg::pixel_t    buf_data,
    output logic               done
);
    import obj_pkg::*;

    draw_state_t state;
    logic [6:0]  slot;
    logic [1:0]  widx;       // word within the slot
    logic [2:0]  cnt;        // pixel within the half
    logic        second;     // working on the second ROM half
    logic        last_slot;

    tbl_word_t   attr;
    rom_word_t   pxl;
    buf_addr_t   pos;

    logic [3:0]  vsub;
    logic        hflip;
    pal_t        pal;
    colour_t     colour;

    // attribute fields, bit 6 (vflip) is resolved by the scan stage
    assign vsub  = attr[11:8];
    assign hflip = attr[5];
    assign pal   = attr[4:0];

    // leftmost pixel sits in the top bit of each plane byte
    assign colour = hflip ? {pxl[24], pxl[16], pxl[8], pxl[0]}
                          : {pxl[31], pxl[23], pxl[15], pxl[7]};

    assign last_slot = (slot == 7'(obj_slots - 1));

    always_comb begin
        case (state)
            read_attr: widx = 2'd0;
            read_code: widx = 2'd1;
            idle:      widx = 2'd0;
            default:   widx = 2'd2;   // x word stays on the bus
        endcase
    end

    assign rd_addr = {slot, widx};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            slot     <= '0;
            cnt      <= '0;
            second   <= 1'b0;
            rom_cs   <= 1'b0;
            rom_half <= 1'b0;
            buf_wr   <= 1'b0;
            done     <= 1'b0;
        end else begin
            buf_wr <= 1'b0;
            done   <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        slot  <= '0;
                        state <= read_attr;
                    end
                end
                read_attr: state <= read_code;
                read_code: state <= read_x;
                read_x: begin
                    rom_cs   <= 1'b1;
                    rom_half <= hflip;   // hflip starts on the right half
                    second   <= 1'b0;
                    state    <= fetch;
                end
                fetch: begin
                    if (rom_ok) begin
                        rom_cs   <= 1'b0;
                        rom_half <= ~rom_half;
                        cnt      <= '0;
                        state    <= plot;
                    end
                end
                plot: begin
                    buf_wr <= 1'b1;
                    cnt    <= cnt + 3'd1;
                    if (cnt == 3'd7) begin
                        if (second) begin
                            state <= next;
                        end else begin
                            second <= 1'b1;
                            rom_cs <= 1'b1;
                            state  <= fetch;
                        end
                    end
                end
                next: begin
                    if (last_slot) begin
                        done  <= 1'b1;
                        state <= idle;
                    end else begin
                        slot  <= slot + 7'd1;
                        state <= read_attr;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // datapath, follows the FSM
    always_ff @(posedge clk) begin
        case (state)
            read_code: attr <= rd_data;
            read_x:    rom_addr <= {rd_data, vsub};   // rd_data is the code here
            fetch: begin
                if (!second) pos <= rd_data[8:0];    // x word
                if (rom_ok)  pxl <= rom_data;
            end
            plot: begin
                buf_addr <= pos;
                buf_data <= {pal, colour};
                pos      <= pos + 9'd1;   // wraps at 512
                pxl      <= hflip ? pxl >> 1 : pxl << 1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: obj_line_buf.sv
`timescale 1ns/1ps
`default_nettype none

module obj_line_buf (
    input  logic               clk,
    input  logic               rst,
    input  logic               swap,
    input  logic               buf_wr,
    input  obj_pkg::buf_addr_t buf_addr,
    input  obj_pkg::pixel_t    buf_data,
    input  logic               pix_rd,
    input  obj_pkg::buf_addr_t pix_addr,
    output obj_pkg::pixel_t    pix_data
);
    import obj_pkg::*;

    pixel_t mem [0:1][0:511];
    logic   sel;    // draw bank, the other one is on display

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < 512; i++) begin
                    mem[b][i] <= pix_clear;
                end
            end
        end else begin
            if (swap) begin
                sel <= ~sel;
            end
            if (buf_wr) begin
                mem[sel][buf_addr] <= buf_data;
            end
            // erase behind the video read
            if (pix_rd) begin
                mem[~sel][pix_addr] <= pix_clear;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_rd) begin
            pix_data <= mem[~sel][pix_addr];
        end
    end

endmodule

`default_nettype wire

// File: obj_line_unit.sv
`timescale 1ns/1ps
`default_nettype none

module obj_line_unit #(
    parameter int obj_slots = 121
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               tbl_we,
    input  obj_pkg::tbl_addr_t tbl_addr,
    input  obj_pkg::tbl_word_t tbl_data,
    input  logic               line_start,
    output logic               rom_cs,
    output logic               rom_half,
    output obj_pkg::rom_addr_t rom_addr,
    input  obj_pkg::rom_word_t rom_data,
    input  logic               rom_ok,
    input  logic               pix_rd,
    input  obj_pkg::buf_addr_t pix_addr,
    output obj_pkg::pixel_t    pix_data,
    output logic               done
);
    import obj_pkg::*;

    tbl_addr_t rd_addr;
    tbl_word_t rd_data;
    logic      buf_wr;
    buf_addr_t buf_addr;
    pixel_t    buf_data;

    // slot index is 7 bits wide
    if (obj_slots < 1 || obj_slots > 128) begin : g_bad_slots
        $error("obj_slots out of range 1..128");
    end

    obj_table #(.obj_slots(obj_slots)) obj_table_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (tbl_we),
        .wr_addr (tbl_addr),
        .wr_data (tbl_data),
        .swap    (line_start),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    obj_draw #(.obj_slots(obj_slots)) obj_draw_i (
        .clk      (clk),
        .rst      (rst),
        .start    (line_start),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rom_cs   (rom_cs),
        .rom_half (rom_half),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .buf_wr   (buf_wr),
        .buf_addr (buf_addr),
        .buf_data (buf_data),
        .done     (done)
    );

    obj_line_buf obj_line_buf_i (
        .clk      (clk),
        .rst      (rst),
        .swap     (line_start),
        .buf_wr   (buf_wr),
        .buf_addr (buf_addr),
        .buf_data (buf_data),
        .pix_rd   (pix_rd),
        .pix_addr (pix_addr),
        .pix_data (pix_data)
    );

endmodule

`default_nettype wire

// File: obj_line_unit_sva.sv
`timescale 1ns/1ps
`default_nettype none

module obj_line_unit_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  start,
    input obj_pkg::draw_state_t  state,
    input logic                  last_slot,
    input logic                  rom_cs,
    input logic                  rom_half,
    input obj_pkg::rom_addr_t    rom_addr,
    input logic                  rom_ok,
    input logic                  buf_wr,
    input logic                  done
);
    import obj_pkg::*;

    // request held steady until the ROM answers
    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr) && $stable(rom_half))
        else $error("rom request dropped or changed before rom_ok");

    a_idle_no_write: assert property (@(posedge clk) disable iff (rst)
        state == idle |-> !buf_wr)
        else $error("pixel write while the draw engine is idle");

    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        state != idle |-> !start)
        else $error("line_start arrived while the draw engine was busy");

    a_done_after_last: assert property (@(posedge clk) disable iff (rst)
        state == next && last_slot |=> done)
        else $error("done missing after the last slot");

    a_done_only_after_last: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(state == next && last_slot))
        else $error("done without a preceding last slot");

endmodule

bind obj_draw obj_line_unit_sva obj_line_unit_sva_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .state     (state),
    .last_slot (last_slot),
    .rom_cs    (rom_cs),
    .rom_half  (rom_half),
    .rom_addr  (rom_addr),
    .rom_ok    (rom_ok),
    .buf_wr    (buf_wr),
    .done      (done)
);

`default_nettype wire

// File: obj_pkg.sv
`default_nettype none

package obj_pkg;

    // object table, 4 words per slot
    typedef logic [8:0]  tbl_addr_t;   // slot * 4 + word index
    typedef logic [15:0] tbl_word_t;

    // graphics ROM
    typedef logic [19:0] rom_addr_t;   // code, then 4-bit sub-row
    typedef logic [31:0] rom_word_t;   // 8 pixels as 4 bit planes

    // pixel fields
    typedef logic [4:0]  pal_t;
    typedef logic [3:0]  colour_t;
    typedef logic [8:0]  pixel_t;      // palette above colour
    typedef logic [8:0]  buf_addr_t;   // wraps at 512

    // draw engine FSM
    typedef enum logic [2:0] {
        idle,
        read_attr,
        read_code,
        read_x,
        fetch,
        plot,
        next
    } draw_state_t;

    // transparent, written back after every video read
    localparam pixel_t pix_clear = '1;

endpackage

`default_nettype wire

// File: obj_table.sv
`timescale 1ns/1ps
`default_nettype none

module obj_table #(
    parameter int obj_slots = 121
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en,
    input  obj_pkg::tbl_addr_t wr_addr,
    input  obj_pkg::tbl_word_t wr_data,
    input  logic               swap,
    input  obj_pkg::tbl_addr_t rd_addr,
    output obj_pkg::tbl_word_t rd_data
);
    import obj_pkg::*;

    localparam int depth = 4 * obj_slots;

    tbl_word_t mem [0:1][0:depth-1];
    logic      sel;    // bank taking scan writes

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (swap) begin
            sel <= ~sel;
        end
    end

    // scan side
    always_ff @(posedge clk) begin
        if (wr_en && (int'(wr_addr) < depth)) begin
            mem[sel][wr_addr] <= wr_data;
        end
    end

    // draw side reads the bank filled during the previous line
    always_ff @(posedge clk) begin
        rd_data <= mem[~sel][rd_addr];
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
if ! verilator --binary --timing --assert --top-module tb_obj_line_unit -f files.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_obj_line_unit > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_obj_line_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_obj_line_unit;
    import obj_pkg::*;

    localparam int obj_slots = 121;
    localparam int timeout_cycles = 4 * obj_slots * 40;
    localparam int min_line_cycles = obj_slots * 22;   // zero-wait ROM
    localparam buf_addr_t visible_w = 9'd320;

    logic      clk;
    logic      rst;
    logic      tbl_we;
    tbl_addr_t tbl_addr;
    tbl_word_t tbl_data;
    logic      line_start;
    logic      rom_cs;
    logic      rom_half;
    rom_addr_t rom_addr;
    rom_word_t rom_data = '0;
    logic      rom_ok = 1'b0;
    logic      pix_rd;
    buf_addr_t pix_addr;
    pixel_t    pix_data;
    logic      done;

    tbl_word_t obj_attr [0:2][0:obj_slots-1];
    tbl_word_t obj_code [0:2][0:obj_slots-1];
    tbl_word_t obj_x    [0:2][0:obj_slots-1];
    pixel_t    exp_line [0:511];

    logic [31:0] stim_lfsr = 32'h8770_170d;
    logic [31:0] rom_lfsr = 32'h8770_170d;
    int          rom_wait = 0;
    int          cycles = 0;
    int          mismatches = 0;
    int          other_errors;
    logic        blank_visible;
    logic        pend_rd = 1'b0;
    buf_addr_t   pend_addr = '0;

    tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    obj_line_unit #(.obj_slots(obj_slots)) obj_line_unit_i (
        .clk(clk), .rst(rst), .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_data(tbl_data),
        .line_start(line_start), .rom_cs(rom_cs), .rom_half(rom_half),
        .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .pix_rd(pix_rd), .pix_addr(pix_addr), .pix_data(pix_data), .done(done)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] take_bits(inout logic [31:0] s, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], s[0]};
            s = lfsr_step(s);
        end
        return v;
    endfunction

    function automatic rom_word_t rom_hash(input rom_addr_t a, input logic h);
        logic [31:0] v;
        v = {11'd0, a, h} * 32'h9e37_79b1;
        v = v ^ (v >> 13);
        v = v * 32'h85eb_ca6b;
        return v ^ (v >> 16);
    endfunction

    // expected line, slots in order so later objects win
    function automatic void paint_line(input int t);
        rom_word_t v;
        rom_addr_t ra;
        logic      fl;
        colour_t   c;
        buf_addr_t p;
        exp_line = '{default: pix_clear};
        for (int s = 0; s < obj_slots; s++) begin
            fl = obj_attr[t][s][5];
            ra = {obj_code[t][s], obj_attr[t][s][11:8]};
            for (int k = 0; k < 2; k++) begin
                v = rom_hash(ra, (k == 0) ? fl : ~fl);   // hflip starts on half 1
                for (int i = 0; i < 8; i++) begin
                    if (fl) begin
                        c = {v[24], v[16], v[8], v[0]};
                        v = v >> 1;
                    end else begin
                        c = {v[31], v[23], v[15], v[7]};
                        v = v << 1;
                    end
                    p = obj_x[t][s][8:0] + 9'(8 * k + i);   // wraps at 512
                    exp_line[p] = {obj_attr[t][s][4:0], c};
                end
            end
        end
    endfunction

    task automatic build_tables();
        logic [3:0] vsub;
        logic       vflip;
        logic       flip_rand;
        pal_t       pal;
        logic       flip;
        for (int t = 0; t < 3; t++) begin
            for (int s = 0; s < obj_slots; s++) begin
                vsub = 4'(take_bits(stim_lfsr, 4));
                vflip = 1'(take_bits(stim_lfsr, 1));
                flip_rand = 1'(take_bits(stim_lfsr, 1));
                pal = 5'(take_bits(stim_lfsr, 5));
                flip = (t == 1) ? 1'b1 : (t == 2) ? flip_rand : 1'b0;
                obj_attr[t][s] = {4'd0, vsub, 1'b0, vflip, flip, pal};
                obj_code[t][s] = 16'(take_bits(stim_lfsr, 16));
                if (t == 2) begin
                    obj_x[t][s] = 16'(visible_w) + 16'(take_bits(stim_lfsr, 7));   // off screen
                end else begin
                    obj_x[t][s] = 16'(take_bits(stim_lfsr, 9));
                end
            end
        end
        obj_x[0][obj_slots-3] = 16'd100;   // overlap pair
        obj_x[0][obj_slots-2] = 16'd108;
        obj_x[0][obj_slots-1] = 16'd505;   // wraps to 0..8
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_table(input int t);
        for (int s = 0; s < obj_slots; s++) begin
            for (int w = 0; w < 3; w++) begin
                tbl_we = 1'b1;
                tbl_addr = tbl_addr_t'(4 * s + w);
                tbl_data = (w == 0) ? obj_attr[t][s] : (w == 1) ? obj_code[t][s] : obj_x[t][s];
                next_cycle();
            end
        end
        tbl_we = 1'b0;
        next_cycle();
    endtask

    task automatic start_line();
        line_start = 1'b1;
        next_cycle();
        line_start = 1'b0;
    endtask

    task automatic run_line();
        int n;
        n = 0;
        start_line();
        do begin
            next_cycle();
            n++;
        end while (!done);
        assert (n >= min_line_cycles) else begin
            other_errors++;
            $display("done came after only %0d cycles, too soon for %0d objects", n, obj_slots);
        end
    endtask

    task automatic read_display();
        for (int a = 0; a < 512; a++) begin
            pix_rd = 1'b1;
            pix_addr = buf_addr_t'(a);
            next_cycle();
        end
        pix_rd = 1'b0;
        next_cycle();   // last compare lands here
    endtask

    // ROM model, 0 to 3 wait cycles per word
    always @(posedge clk) begin
        #1;
        rom_ok = 1'b0;
        if (rom_cs) begin
            if (rom_wait == 0) begin
                rom_ok = 1'b1;
                rom_data = rom_hash(rom_addr, rom_half);
                rom_wait = int'(take_bits(rom_lfsr, 2));
            end else begin
                rom_wait--;
            end
        end
    end

    // pixel checker, data shows up one cycle after the read
    always @(negedge clk) begin
        if (pend_rd) begin
            assert (pix_data == exp_line[pend_addr]) else begin
                mismatches++;
                $display("MISMATCH at %0t: pixel %0d read %03h, expected %03h",
                         $time, pend_addr, pix_data, exp_line[pend_addr]);
            end
            if (blank_visible && pend_addr < visible_w) begin
                assert (pix_data == pix_clear) else begin
                    mismatches++;
                    $display("MISMATCH at %0t: visible pixel %0d read %03h, expected clear",
                             $time, pend_addr, pix_data);
                end
            end
        end
        pend_rd = pix_rd;
        pend_addr = pix_addr;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        tbl_we = 1'b0;
        tbl_addr = '0;
        tbl_data = '0;
        line_start = 1'b0;
        pix_rd = 1'b0;
        pix_addr = '0;
        other_errors = 0;
        blank_visible = 1'b0;
        build_tables();
        @(negedge rst);
        next_cycle();
        load_table(0);
        run_line();
        load_table(1);
        run_line();
        paint_line(0);                   // random, wrap and overlap line
        read_display();
        exp_line = '{default: pix_clear};   // read-and-clear leaves nothing
        read_display();
        load_table(2);
        run_line();
        paint_line(1);                   // hflip line
        read_display();
        start_line();                    // off-screen line goes on display
        paint_line(2);
        blank_visible = 1'b1;
        read_display();
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
